//--- source/sv32_pkg.sv
// ----------------------------------------------------------------------
// Sv32 address and page table entry formats
// physical addresses are 34 bits, virtual addresses are all 32 bits
// ----------------------------------------------------------------------
`default_nettype none

package sv32_pkg;

  // address and field widths
  localparam int unsigned VLEN  = 32;
  localparam int unsigned PLEN  = 34;
  localparam int unsigned PPNW  = 22;
  localparam int unsigned ASIDW = 9;

  // tlb depths
  localparam int unsigned ITLB_ENTRIES = 4;
  localparam int unsigned DTLB_ENTRIES = 4;

  // leaf page table entry, msb first as in memory
  typedef struct packed {
    logic [PPNW-1:0] ppn;
    logic [1:0]      rsw;
    logic            d;
    logic            a;
    logic            g;
    logic            u;
    logic            x;
    logic            w;
    logic            r;
    logic            v;
  } pte_t;

  // split of a virtual address for a 4 KiB page
  typedef struct packed {
    logic [9:0]  vpn1;
    logic [9:0]  vpn0;
    logic [11:0] offset;
  } va_4k_t;

  // split of a virtual address for a 4 MiB megapage
  typedef struct packed {
    logic [9:0]  vpn1;
    logic [21:0] moff;
  } va_4m_t;

  // one address word, read through either page size
  typedef union packed {
    va_4k_t k4;
    va_4m_t m4;
  } vaddr_t;

endpackage

`default_nettype wire

//--- source/mmu_exc_pkg.sv
// ----------------------------------------------------------------------
// privilege levels and exception causes seen by the MMU
// only page faults are raised here, other causes pass through
// ----------------------------------------------------------------------
`default_nettype none

package mmu_exc_pkg;

  // field widths
  localparam int unsigned PRIVW  = 2;
  localparam int unsigned CAUSEW = 5;

  // ----------------------------------------------------------------------
  // privilege encodings (2 is reserved)
  // ----------------------------------------------------------------------
  localparam logic [PRIVW-1:0] PRIV_U = 2'd0;
  localparam logic [PRIVW-1:0] PRIV_S = 2'd1;
  localparam logic [PRIVW-1:0] PRIV_M = 2'd3;

  // ----------------------------------------------------------------------
  // mcause codes for page faults
  // ----------------------------------------------------------------------
  // fetch from a page the current mode may not execute from
  localparam logic [CAUSEW-1:0] CAUSE_INSTR_PAGE_FAULT = 5'd12;
  // load denied by the page permissions
  localparam logic [CAUSEW-1:0] CAUSE_LOAD_PAGE_FAULT  = 5'd13;
  // store denied, also covers a clear dirty bit
  localparam logic [CAUSEW-1:0] CAUSE_STORE_PAGE_FAULT = 5'd15;

endpackage

`default_nettype wire

//--- source/sv32_tlb.sv
// ----------------------------------------------------------------------
// fully associative Sv32 TLB, 4 KiB and 4 MiB entries
// lookup is combinational, a refill shows up one cycle later
// a flush in the same cycle as a refill is applied first
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sv32_tlb #(
  parameter int unsigned TLB_ENTRIES = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,
  input  logic [sv32_pkg::ASIDW-1:0] flush_asid_i,
  input  sv32_pkg::vaddr_t           flush_vaddr_i,
  input  logic                       upd_valid_i,
  input  sv32_pkg::vaddr_t           upd_vaddr_i,
  input  logic [sv32_pkg::ASIDW-1:0] upd_asid_i,
  input  logic                       upd_is_4m_i,
  input  sv32_pkg::pte_t             upd_pte_i,
  input  sv32_pkg::vaddr_t           lu_vaddr_i,
  input  logic [sv32_pkg::ASIDW-1:0] lu_asid_i,
  output sv32_pkg::pte_t             lu_pte_o,
  output logic                       lu_is_4m_o,
  output logic                       lu_hit_o
);

  localparam int unsigned IDXW = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

  // tag and pte storage
  logic [9:0]                 vpn1_q [TLB_ENTRIES];
  logic [9:0]                 vpn0_q [TLB_ENTRIES];
  logic [sv32_pkg::ASIDW-1:0] asid_q [TLB_ENTRIES];
  sv32_pkg::pte_t             pte_q  [TLB_ENTRIES];
  logic [TLB_ENTRIES-1:0]     is_4m_q;

  logic [TLB_ENTRIES-1:0] valid_q, valid_n;
  logic [TLB_ENTRIES-1:0] lu_match, fl_page, fl_asid, fl_match;
  logic [IDXW-1:0]        victim_q, wr_idx;
  logic                   free_found;
  logic                   fl_asid_zero, fl_va_zero;

  assign fl_asid_zero = (flush_asid_i == '0);
  assign fl_va_zero   = (flush_vaddr_i == '0);

  // ----------------------------------------------------------------------
  // per entry match for lookup and flush
  // ----------------------------------------------------------------------
  always_comb begin : match_comb
    for (int unsigned i = 0; i < TLB_ENTRIES; i++) begin
      // megapage entries ignore vpn0
      lu_match[i] = valid_q[i] && (vpn1_q[i] == lu_vaddr_i.k4.vpn1)
                    && (is_4m_q[i] || (vpn0_q[i] == lu_vaddr_i.k4.vpn0))
                    && (pte_q[i].g || (asid_q[i] == lu_asid_i));
      fl_page[i]  = (vpn1_q[i] == flush_vaddr_i.k4.vpn1)
                    && (is_4m_q[i] || (vpn0_q[i] == flush_vaddr_i.k4.vpn0));
      fl_asid[i]  = (asid_q[i] == flush_asid_i);
      // zero asid or zero vaddr widens the flush
      if (fl_asid_zero && fl_va_zero) fl_match[i] = 1'b1;
      else if (fl_asid_zero)          fl_match[i] = fl_page[i];
      else if (fl_va_zero)            fl_match[i] = !pte_q[i].g && fl_asid[i];
      else                            fl_match[i] = fl_page[i] && fl_asid[i];
    end
  end

  // lowest matching index wins
  always_comb begin : lookup_comb
    lu_hit_o   = 1'b0;
    lu_pte_o   = '0;
    lu_is_4m_o = 1'b0;
    for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
      if (lu_match[i]) begin
        lu_hit_o   = 1'b1;
        lu_pte_o   = pte_q[i];
        lu_is_4m_o = is_4m_q[i];
      end
    end
  end

  // ----------------------------------------------------------------------
  // flush, then pick the refill slot
  // ----------------------------------------------------------------------
  always_comb begin : refill_comb
    valid_n = flush_i ? (valid_q & ~fl_match) : valid_q;
    // lowest free slot, else the round robin victim
    free_found = 1'b0;
    wr_idx     = victim_q;
    for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
      if (!valid_n[i]) begin
        free_found = 1'b1;
        wr_idx     = IDXW'(i);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_ff
    if (!rst_ni) begin
      valid_q  <= '0;
      victim_q <= '0;
    end else begin
      valid_q <= valid_n;
      if (upd_valid_i) begin
        valid_q[wr_idx] <= 1'b1;
        // victim only moves when an entry was evicted
        if (!free_found) begin
          victim_q <= (victim_q == IDXW'(TLB_ENTRIES - 1)) ? '0 : victim_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin : entry_ff
    if (upd_valid_i) begin
      vpn1_q[wr_idx]  <= upd_vaddr_i.k4.vpn1;
      vpn0_q[wr_idx]  <= upd_vaddr_i.k4.vpn0;
      asid_q[wr_idx]  <= upd_asid_i;
      pte_q[wr_idx]   <= upd_pte_i;
      is_4m_q[wr_idx] <= upd_is_4m_i;
    end
  end

  // refills only ever install leaf entries that are valid
  a_refill_pte_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    upd_valid_i |-> upd_pte_i.v)
    else $error("tlb refill with pte.v clear");

endmodule

`default_nettype wire

//--- source/instr_xlate.sv
// ----------------------------------------------------------------------
// fetch address translation, purely combinational
// an ITLB miss gives no valid response until the entry is refilled
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module instr_xlate (
  input  logic                            fetch_req_i,
  input  sv32_pkg::vaddr_t                fetch_vaddr_i,
  input  logic                            enable_translation_i,
  input  logic [mmu_exc_pkg::PRIVW-1:0]   priv_lvl_i,
  input  sv32_pkg::pte_t                  itlb_pte_i,
  input  logic                            itlb_is_4m_i,
  input  logic                            itlb_hit_i,
  output logic                            fetch_valid_o,
  output logic [sv32_pkg::PLEN-1:0]       fetch_paddr_o,
  output logic                            fetch_ex_valid_o,
  output logic [mmu_exc_pkg::CAUSEW-1:0]  fetch_ex_cause_o,
  output logic [sv32_pkg::VLEN-1:0]       fetch_ex_tval_o,
  output logic                            itlb_miss_o
);

  logic iaccess_err;

  // u mode needs a u page, s mode must not fetch from one
  // m mode never faults on the u bit
  assign iaccess_err = fetch_req_i
                       && (((priv_lvl_i == mmu_exc_pkg::PRIV_U) && !itlb_pte_i.u)
                       ||  ((priv_lvl_i == mmu_exc_pkg::PRIV_S) &&  itlb_pte_i.u));

  always_comb begin : fetch_comb
    // translation off, pass the address straight through
    fetch_valid_o    = fetch_req_i;
    fetch_paddr_o    = {{(sv32_pkg::PLEN - sv32_pkg::VLEN){1'b0}}, fetch_vaddr_i};
    fetch_ex_valid_o = 1'b0;
    fetch_ex_cause_o = '0;
    fetch_ex_tval_o  = '0;
    if (enable_translation_i) begin
      fetch_valid_o = 1'b0;
      // 4 KiB page
      fetch_paddr_o = {itlb_pte_i.ppn, fetch_vaddr_i.k4.offset};
      // megapage keeps vaddr bits 21:12
      if (itlb_is_4m_i) begin
        fetch_paddr_o[21:12] = fetch_vaddr_i.m4.moff[21:12];
      end
      if (itlb_hit_i) begin
        fetch_valid_o = fetch_req_i;
        if (iaccess_err) begin
          fetch_ex_valid_o = 1'b1;
          fetch_ex_cause_o = mmu_exc_pkg::CAUSE_INSTR_PAGE_FAULT;
          fetch_ex_tval_o  = fetch_vaddr_i;
        end
      end
    end
  end

  // counts fetches that need a refill
  assign itlb_miss_o = fetch_req_i && enable_translation_i && !itlb_hit_i;

  // a fault is only ever reported against a live fetch
  always_comb begin : ex_check
    a_ex_needs_req: assert (!fetch_ex_valid_o || fetch_req_i)
      else $error("fetch exception without fetch request");
  end

endmodule

`default_nettype wire

//--- source/data_xlate.sv
// ----------------------------------------------------------------------
// load/store translation, hit and ppn in cycle 0, result in cycle 1
// a misaligned exception wins over any page fault
// control levels are sampled live in cycle 1
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module data_xlate (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            lsu_req_i,
  input  sv32_pkg::vaddr_t                lsu_vaddr_i,
  input  logic                            lsu_is_store_i,
  input  logic                            mis_valid_i,
  input  logic [mmu_exc_pkg::CAUSEW-1:0]  mis_cause_i,
  input  logic [sv32_pkg::VLEN-1:0]       mis_tval_i,
  input  logic                            en_ld_st_translation_i,
  input  logic [mmu_exc_pkg::PRIVW-1:0]   ld_st_priv_lvl_i,
  input  logic                            sum_i,
  input  sv32_pkg::pte_t                  dtlb_pte_i,
  input  logic                            dtlb_is_4m_i,
  input  logic                            dtlb_hit_i,
  output logic                            lsu_dtlb_hit_o,
  output logic [sv32_pkg::PPNW-1:0]       lsu_dtlb_ppn_o,
  output logic                            lsu_valid_o,
  output logic [sv32_pkg::PLEN-1:0]       lsu_paddr_o,
  output logic                            lsu_ex_valid_o,
  output logic [mmu_exc_pkg::CAUSEW-1:0]  lsu_ex_cause_o,
  output logic [sv32_pkg::VLEN-1:0]       lsu_ex_tval_o,
  output logic                            dtlb_miss_o
);

  // request stage
  sv32_pkg::vaddr_t                lsu_vaddr_q;
  sv32_pkg::pte_t                  dtlb_pte_q;
  logic                            lsu_req_q, lsu_is_store_q;
  logic                            dtlb_hit_q, dtlb_is_4m_q;
  logic                            mis_valid_q;
  logic [mmu_exc_pkg::CAUSEW-1:0]  mis_cause_q;
  logic [sv32_pkg::VLEN-1:0]       mis_tval_q;
  logic                            daccess_err;

  // ----------------------------------------------------------------------
  // cycle 0
  // ----------------------------------------------------------------------
  // always a hit when not translating
  assign lsu_dtlb_hit_o = en_ld_st_translation_i ? dtlb_hit_i : 1'b1;
  assign dtlb_miss_o    = lsu_req_i && en_ld_st_translation_i && !dtlb_hit_i;

  always_comb begin : ppn_comb
    lsu_dtlb_ppn_o = {{(sv32_pkg::PPNW - 20){1'b0}}, lsu_vaddr_i[31:12]};
    if (en_ld_st_translation_i) begin
      lsu_dtlb_ppn_o = dtlb_pte_i.ppn;
      // megapage, low ppn bits come from the vaddr
      if (dtlb_is_4m_i) begin
        lsu_dtlb_ppn_o[9:0] = lsu_vaddr_i.m4.moff[21:12];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : req_ff
    if (!rst_ni) begin
      lsu_req_q      <= 1'b0;
      lsu_vaddr_q    <= '0;
      lsu_is_store_q <= 1'b0;
      dtlb_pte_q     <= '0;
      dtlb_hit_q     <= 1'b0;
      dtlb_is_4m_q   <= 1'b0;
      mis_valid_q    <= 1'b0;
      mis_cause_q    <= '0;
      mis_tval_q     <= '0;
    end else begin
      lsu_req_q      <= lsu_req_i;
      lsu_vaddr_q    <= lsu_vaddr_i;
      lsu_is_store_q <= lsu_is_store_i;
      dtlb_pte_q     <= dtlb_pte_i;
      dtlb_hit_q     <= dtlb_hit_i;
      dtlb_is_4m_q   <= dtlb_is_4m_i;
      // a misaligned flag without a request is ignored
      mis_valid_q    <= mis_valid_i && lsu_req_i;
      mis_cause_q    <= mis_cause_i;
      mis_tval_q     <= mis_tval_i;
    end
  end

  // ----------------------------------------------------------------------
  // cycle 1
  // ----------------------------------------------------------------------
  // s mode needs sum for u pages, u mode needs a u page
  assign daccess_err = ((ld_st_priv_lvl_i == mmu_exc_pkg::PRIV_S) && !sum_i && dtlb_pte_q.u)
                    || ((ld_st_priv_lvl_i == mmu_exc_pkg::PRIV_U) && !dtlb_pte_q.u);

  always_comb begin : result_comb
    // pass through, with whatever misaligned fault came along
    lsu_valid_o    = lsu_req_q;
    lsu_paddr_o    = {{(sv32_pkg::PLEN - sv32_pkg::VLEN){1'b0}}, lsu_vaddr_q};
    lsu_ex_valid_o = mis_valid_q;
    lsu_ex_cause_o = mis_cause_q;
    lsu_ex_tval_o  = mis_tval_q;
    if (en_ld_st_translation_i && !mis_valid_q) begin
      lsu_valid_o = 1'b0;
      lsu_paddr_o = {dtlb_pte_q.ppn, lsu_vaddr_q.k4.offset};
      if (dtlb_is_4m_q) begin
        lsu_paddr_o[21:12] = lsu_vaddr_q.m4.moff[21:12];
      end
      if (dtlb_hit_q && lsu_req_q) begin
        lsu_valid_o = 1'b1;
        // store also needs w and an already set dirty bit
        if (lsu_is_store_q && (!dtlb_pte_q.w || !dtlb_pte_q.d || daccess_err)) begin
          lsu_ex_valid_o = 1'b1;
          lsu_ex_cause_o = mmu_exc_pkg::CAUSE_STORE_PAGE_FAULT;
          lsu_ex_tval_o  = lsu_vaddr_q;
        end else if (!lsu_is_store_q && daccess_err) begin
          lsu_ex_valid_o = 1'b1;
          lsu_ex_cause_o = mmu_exc_pkg::CAUSE_LOAD_PAGE_FAULT;
          lsu_ex_tval_o  = lsu_vaddr_q;
        end
      end
    end
  end

  // every cycle 1 answer belongs to a request one cycle earlier
  a_valid_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_valid_o |-> $past(lsu_req_i))
    else $error("lsu_valid_o without a request in the previous cycle");

endmodule

`default_nettype wire

//--- source/sv32_mmu.sv
// ----------------------------------------------------------------------
// Sv32 MMU front end, ITLB and DTLB with their translation paths
// no page table walker, entries come in through the refill strobes
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sv32_mmu (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // fetch side
  input  logic                            fetch_req_i,
  input  sv32_pkg::vaddr_t                fetch_vaddr_i,
  output logic                            fetch_valid_o,
  output logic [sv32_pkg::PLEN-1:0]       fetch_paddr_o,
  output logic                            fetch_ex_valid_o,
  output logic [mmu_exc_pkg::CAUSEW-1:0]  fetch_ex_cause_o,
  output logic [sv32_pkg::VLEN-1:0]       fetch_ex_tval_o,
  // load/store side
  input  logic                            lsu_req_i,
  input  sv32_pkg::vaddr_t                lsu_vaddr_i,
  input  logic                            lsu_is_store_i,
  input  logic                            mis_valid_i,
  input  logic [mmu_exc_pkg::CAUSEW-1:0]  mis_cause_i,
  input  logic [sv32_pkg::VLEN-1:0]       mis_tval_i,
  output logic                            lsu_dtlb_hit_o,
  output logic [sv32_pkg::PPNW-1:0]       lsu_dtlb_ppn_o,
  output logic                            lsu_valid_o,
  output logic [sv32_pkg::PLEN-1:0]       lsu_paddr_o,
  output logic                            lsu_ex_valid_o,
  output logic [mmu_exc_pkg::CAUSEW-1:0]  lsu_ex_cause_o,
  output logic [sv32_pkg::VLEN-1:0]       lsu_ex_tval_o,
  // control levels
  input  logic                            enable_translation_i,
  input  logic                            en_ld_st_translation_i,
  input  logic [mmu_exc_pkg::PRIVW-1:0]   priv_lvl_i,
  input  logic [mmu_exc_pkg::PRIVW-1:0]   ld_st_priv_lvl_i,
  input  logic                            sum_i,
  input  logic [sv32_pkg::ASIDW-1:0]      asid_i,
  // refill, shared by both tlbs
  input  logic                            itlb_upd_valid_i,
  input  logic                            dtlb_upd_valid_i,
  input  sv32_pkg::vaddr_t                upd_vaddr_i,
  input  logic [sv32_pkg::ASIDW-1:0]      upd_asid_i,
  input  logic                            upd_is_4m_i,
  input  sv32_pkg::pte_t                  upd_pte_i,
  // flush, applied to both tlbs
  input  logic                            flush_tlb_i,
  input  logic [sv32_pkg::ASIDW-1:0]      flush_asid_i,
  input  sv32_pkg::vaddr_t                flush_vaddr_i,
  // miss pulses
  output logic                            itlb_miss_o,
  output logic                            dtlb_miss_o
);

  sv32_pkg::pte_t itlb_pte, dtlb_pte;
  logic           itlb_is_4m, itlb_hit;
  logic           dtlb_is_4m, dtlb_hit;

  sv32_tlb #(.TLB_ENTRIES(sv32_pkg::ITLB_ENTRIES)) i_itlb (
    .clk_i, .rst_ni,
    .flush_i (flush_tlb_i), .flush_asid_i, .flush_vaddr_i,
    .upd_valid_i (itlb_upd_valid_i), .upd_vaddr_i, .upd_asid_i, .upd_is_4m_i, .upd_pte_i,
    .lu_vaddr_i (fetch_vaddr_i), .lu_asid_i (asid_i),
    .lu_pte_o (itlb_pte), .lu_is_4m_o (itlb_is_4m), .lu_hit_o (itlb_hit)
  );

  sv32_tlb #(.TLB_ENTRIES(sv32_pkg::DTLB_ENTRIES)) i_dtlb (
    .clk_i, .rst_ni,
    .flush_i (flush_tlb_i), .flush_asid_i, .flush_vaddr_i,
    .upd_valid_i (dtlb_upd_valid_i), .upd_vaddr_i, .upd_asid_i, .upd_is_4m_i, .upd_pte_i,
    .lu_vaddr_i (lsu_vaddr_i), .lu_asid_i (asid_i),
    .lu_pte_o (dtlb_pte), .lu_is_4m_o (dtlb_is_4m), .lu_hit_o (dtlb_hit)
  );

  instr_xlate i_instr_xlate (
    .fetch_req_i, .fetch_vaddr_i, .enable_translation_i, .priv_lvl_i,
    .itlb_pte_i (itlb_pte), .itlb_is_4m_i (itlb_is_4m), .itlb_hit_i (itlb_hit),
    .fetch_valid_o, .fetch_paddr_o, .fetch_ex_valid_o, .fetch_ex_cause_o,
    .fetch_ex_tval_o, .itlb_miss_o
  );

  data_xlate i_data_xlate (
    .clk_i, .rst_ni, .lsu_req_i, .lsu_vaddr_i, .lsu_is_store_i,
    .mis_valid_i, .mis_cause_i, .mis_tval_i,
    .en_ld_st_translation_i, .ld_st_priv_lvl_i, .sum_i,
    .dtlb_pte_i (dtlb_pte), .dtlb_is_4m_i (dtlb_is_4m), .dtlb_hit_i (dtlb_hit),
    .lsu_dtlb_hit_o, .lsu_dtlb_ppn_o, .lsu_valid_o, .lsu_paddr_o,
    .lsu_ex_valid_o, .lsu_ex_cause_o, .lsu_ex_tval_o, .dtlb_miss_o
  );

endmodule

`default_nettype wire

//--- sim/tb_mmu_model.svh
// ----------------------------------------------------------------------
// reference model of both TLBs, index 0 is the ITLB and 1 the DTLB
// included inside the testbench module, state lives in its scope
// ----------------------------------------------------------------------
`ifndef TB_MMU_MODEL_SVH
`define TB_MMU_MODEL_SVH

localparam int unsigned MAXE = 8;

logic                       ent_valid [2][MAXE];
logic [9:0]                 ent_vpn1  [2][MAXE];
logic [9:0]                 ent_vpn0  [2][MAXE];
logic [sv32_pkg::ASIDW-1:0] ent_asid  [2][MAXE];
logic                       ent_is4m  [2][MAXE];
sv32_pkg::pte_t             ent_pte   [2][MAXE];
int unsigned                victim    [2];
int unsigned                depth     [2];

function automatic void clear_tlbs();
  depth[0] = sv32_pkg::ITLB_ENTRIES;
  depth[1] = sv32_pkg::DTLB_ENTRIES;
  for (int t = 0; t < 2; t++) begin
    victim[t] = 0;
    for (int i = 0; i < MAXE; i++) begin
      ent_valid[t][i] = 1'b0;
    end
  end
endfunction

// a megapage covers any vpn0
function automatic logic page_covers(input int t, input int i, input logic [31:0] va);
  return (ent_vpn1[t][i] == va[31:22]) && (ent_is4m[t][i] || (ent_vpn0[t][i] == va[21:12]));
endfunction

// first valid entry in index order decides
function automatic void lookup_entry(input int t, input logic [31:0] va,
                                     input logic [sv32_pkg::ASIDW-1:0] asid,
                                     output logic hit, output sv32_pkg::pte_t pte,
                                     output logic is4m);
  hit  = 1'b0;
  pte  = '0;
  is4m = 1'b0;
  for (int i = 0; i < depth[t]; i++) begin
    if (!hit && ent_valid[t][i] && page_covers(t, i, va)
        && (ent_pte[t][i].g || (ent_asid[t][i] == asid))) begin
      hit  = 1'b1;
      pte  = ent_pte[t][i];
      is4m = ent_is4m[t][i];
    end
  end
endfunction

// zero asid and zero vaddr each widen the selection
function automatic void flush_entries(input logic [sv32_pkg::ASIDW-1:0] asid,
                                      input logic [31:0] va);
  logic sel;
  for (int t = 0; t < 2; t++) begin
    for (int i = 0; i < depth[t]; i++) begin
      if (asid == '0 && va == '0) sel = 1'b1;
      else if (asid == '0) sel = page_covers(t, i, va);
      else if (va == '0) sel = !ent_pte[t][i].g && (ent_asid[t][i] == asid);
      else sel = page_covers(t, i, va) && (ent_asid[t][i] == asid);
      if (sel) ent_valid[t][i] = 1'b0;
    end
  end
endfunction

// lowest free slot, else evict at the victim pointer
function automatic void refill_entry(input int t, input logic [31:0] va,
                                     input logic [sv32_pkg::ASIDW-1:0] asid,
                                     input logic is4m, input sv32_pkg::pte_t pte);
  int slot;
  slot = -1;
  for (int i = 0; i < depth[t]; i++) begin
    if (slot < 0 && !ent_valid[t][i]) slot = i;
  end
  if (slot < 0) begin
    slot      = victim[t];
    victim[t] = (victim[t] + 1) % depth[t];
  end
  ent_valid[t][slot] = 1'b1;
  ent_vpn1[t][slot]  = va[31:22];
  ent_vpn0[t][slot]  = va[21:12];
  ent_asid[t][slot]  = asid;
  ent_is4m[t][slot]  = is4m;
  ent_pte[t][slot]   = pte;
endfunction

// 4 MiB pages keep vaddr bits 21:12
function automatic logic [33:0] expected_paddr(input sv32_pkg::pte_t pte, input logic is4m,
                                               input logic [31:0] va);
  if (is4m) return {pte.ppn[21:10], va[21:0]};
  return {pte.ppn, va[11:0]};
endfunction

`endif

//--- sim/tb_sv32_mmu.sv
// ----------------------------------------------------------------------
// random traffic over a small page pool from a fixed seed
// outputs are sampled mid cycle and inputs change 1 ns after the edge
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_sv32_mmu;

  localparam logic [31:0] SEED = 32'ha3fc0df4;

  logic                             clk_i, rst_ni;
  logic                             fetch_req_i, fetch_valid_o, fetch_ex_valid_o;
  logic [31:0]                      fetch_vaddr_i, fetch_ex_tval_o;
  logic [sv32_pkg::PLEN-1:0]        fetch_paddr_o, lsu_paddr_o;
  logic [mmu_exc_pkg::CAUSEW-1:0]   fetch_ex_cause_o, mis_cause_i, lsu_ex_cause_o;
  logic                             lsu_req_i, lsu_is_store_i, mis_valid_i;
  logic [31:0]                      lsu_vaddr_i, mis_tval_i, lsu_ex_tval_o;
  logic                             lsu_dtlb_hit_o, lsu_valid_o, lsu_ex_valid_o;
  logic [sv32_pkg::PPNW-1:0]        lsu_dtlb_ppn_o;
  logic                             enable_translation_i, en_ld_st_translation_i, sum_i;
  logic [mmu_exc_pkg::PRIVW-1:0]    priv_lvl_i, ld_st_priv_lvl_i;
  logic [sv32_pkg::ASIDW-1:0]       asid_i, upd_asid_i, flush_asid_i;
  logic                             itlb_upd_valid_i, dtlb_upd_valid_i, upd_is_4m_i;
  logic [31:0]                      upd_vaddr_i, flush_vaddr_i;
  sv32_pkg::pte_t                   upd_pte_i;
  logic                             flush_tlb_i, itlb_miss_o, dtlb_miss_o;

  // last cycle's data request as the model saw it
  logic                             s_req, s_store, s_hit, s_is4m, s_mis;
  logic [31:0]                      s_vaddr, s_tval;
  logic [mmu_exc_pkg::CAUSEW-1:0]   s_cause;
  sv32_pkg::pte_t                   s_pte;
  int unsigned                      errors, cycles;

  `include "tb_mmu_model.svh"

  sv32_mmu dut_i (.*);

  always #5 clk_i = ~clk_i;

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    errors++;
    $display("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
  endtask

  // two vpn1 and four vpn0 values keep hits frequent
  function automatic logic [31:0] pool_vaddr();
    return {10'($urandom_range(0, 1)), 10'($urandom_range(0, 3)), 12'($urandom)};
  endfunction

  function automatic logic [1:0] pick_priv();
    case ($urandom_range(0, 2))
      0:       return mmu_exc_pkg::PRIV_U;
      1:       return mmu_exc_pkg::PRIV_S;
      default: return mmu_exc_pkg::PRIV_M;
    endcase
  endfunction

  task automatic init_inputs();
    clk_i = 1'b0;
    rst_ni = 1'b0;
    {fetch_req_i, lsu_req_i, lsu_is_store_i, mis_valid_i, sum_i} = '0;
    {fetch_vaddr_i, lsu_vaddr_i, mis_tval_i, mis_cause_i} = '0;
    {enable_translation_i, en_ld_st_translation_i, priv_lvl_i, ld_st_priv_lvl_i} = '0;
    {asid_i, upd_asid_i, flush_asid_i, upd_vaddr_i, flush_vaddr_i} = '0;
    {itlb_upd_valid_i, dtlb_upd_valid_i, upd_is_4m_i, flush_tlb_i} = '0;
    upd_pte_i = '0;
    {s_req, s_store, s_hit, s_is4m, s_mis, s_vaddr, s_tval, s_cause} = '0;
    s_pte = '0;
  endtask

  // mode 0 translation off, 1 mixed traffic, 2 a data request every cycle
  task automatic drive_inputs(input int mode);
    fetch_req_i            = ($urandom_range(0, 3) != 0);
    fetch_vaddr_i          = pool_vaddr();
    lsu_req_i              = (mode == 2) || ($urandom_range(0, 3) != 0);
    lsu_vaddr_i            = pool_vaddr();
    lsu_is_store_i         = ($urandom_range(0, 1) != 0);
    mis_valid_i            = ($urandom_range(0, 7) == 0);
    mis_cause_i            = lsu_is_store_i ? 5'd6 : 5'd4;
    mis_tval_i             = $urandom;
    enable_translation_i   = (mode != 0) && ($urandom_range(0, 7) != 0);
    en_ld_st_translation_i = (mode != 0) && ($urandom_range(0, 7) != 0);
    priv_lvl_i             = pick_priv();
    ld_st_priv_lvl_i       = pick_priv();
    sum_i                  = ($urandom_range(0, 1) != 0);
    asid_i                 = 9'($urandom_range(1, 2));
    itlb_upd_valid_i       = (mode != 0) && ($urandom_range(0, 3) == 0);
    dtlb_upd_valid_i       = (mode != 0) && ($urandom_range(0, 3) == 0);
    upd_vaddr_i            = pool_vaddr();
    upd_asid_i             = 9'($urandom_range(0, 2));
    upd_is_4m_i            = ($urandom_range(0, 3) == 0);
    upd_pte_i              = $urandom;
    upd_pte_i.v            = 1'b1;
    upd_pte_i.g            = ($urandom_range(0, 3) == 0);
    flush_tlb_i            = (mode != 0) && ($urandom_range(0, 15) == 0);
    flush_asid_i           = 9'($urandom_range(0, 2));
    flush_vaddr_i          = ($urandom_range(0, 1) != 0) ? pool_vaddr() : 32'h0;
  endtask

  task automatic check_outputs();
    logic hit, is4m, deny, e_valid, e_exv, e_miss;
    sv32_pkg::pte_t pte;
    logic [33:0] e_pa;
    logic [4:0] e_cause;
    logic [31:0] e_tval;
    // cycle 1 result of last cycle's request under live control levels
    deny = ((ld_st_priv_lvl_i == mmu_exc_pkg::PRIV_S) && !sum_i && s_pte.u)
           || ((ld_st_priv_lvl_i == mmu_exc_pkg::PRIV_U) && !s_pte.u);
    if (!en_ld_st_translation_i || s_mis) begin
      e_valid = s_req;
      e_pa    = {2'b0, s_vaddr};
      e_exv   = s_mis;
      e_cause = s_cause;
      e_tval  = s_tval;
    end else begin
      e_valid = s_req && s_hit;
      e_pa    = expected_paddr(s_pte, s_is4m, s_vaddr);
      e_exv   = e_valid && (deny || (s_store && (!s_pte.w || !s_pte.d)));
      e_cause = s_store ? mmu_exc_pkg::CAUSE_STORE_PAGE_FAULT
                        : mmu_exc_pkg::CAUSE_LOAD_PAGE_FAULT;
      e_tval  = s_vaddr;
    end
    if (lsu_valid_o !== e_valid)
      report_mismatch("lsu_valid_o", 64'(lsu_valid_o), 64'(e_valid));
    if (e_valid && lsu_paddr_o !== e_pa)
      report_mismatch("lsu_paddr_o", 64'(lsu_paddr_o), 64'(e_pa));
    if (lsu_ex_valid_o !== e_exv)
      report_mismatch("lsu_ex_valid_o", 64'(lsu_ex_valid_o), 64'(e_exv));
    if (e_exv && lsu_ex_cause_o !== e_cause)
      report_mismatch("lsu_ex_cause_o", 64'(lsu_ex_cause_o), 64'(e_cause));
    if (e_exv && lsu_ex_tval_o !== e_tval)
      report_mismatch("lsu_ex_tval_o", 64'(lsu_ex_tval_o), 64'(e_tval));
    // cycle 0 of this request is saved for the next check
    lookup_entry(1, lsu_vaddr_i, asid_i, hit, pte, is4m);
    e_valid = !en_ld_st_translation_i || hit;
    e_pa = en_ld_st_translation_i ? expected_paddr(pte, is4m, lsu_vaddr_i) : {2'b0, lsu_vaddr_i};
    if (lsu_dtlb_hit_o !== e_valid)
      report_mismatch("lsu_dtlb_hit_o", 64'(lsu_dtlb_hit_o), 64'(e_valid));
    if (e_valid && lsu_dtlb_ppn_o !== e_pa[33:12])
      report_mismatch("lsu_dtlb_ppn_o", 64'(lsu_dtlb_ppn_o), 64'(e_pa[33:12]));
    e_miss = lsu_req_i && en_ld_st_translation_i && !hit;
    if (dtlb_miss_o !== e_miss)
      report_mismatch("dtlb_miss_o", 64'(dtlb_miss_o), 64'(e_miss));
    {s_req, s_store, s_hit, s_is4m, s_pte, s_vaddr} = {lsu_req_i, lsu_is_store_i, hit, is4m,
                                                       pte, lsu_vaddr_i};
    {s_mis, s_cause, s_tval} = {mis_valid_i && lsu_req_i, mis_cause_i, mis_tval_i};
    // fetch path is purely combinational
    lookup_entry(0, fetch_vaddr_i, asid_i, hit, pte, is4m);
    e_valid = fetch_req_i && (!enable_translation_i || hit);
    e_pa = enable_translation_i ? expected_paddr(pte, is4m, fetch_vaddr_i)
                                : {2'b0, fetch_vaddr_i};
    deny = ((priv_lvl_i == mmu_exc_pkg::PRIV_U) && !pte.u)
           || ((priv_lvl_i == mmu_exc_pkg::PRIV_S) && pte.u);
    e_exv = e_valid && enable_translation_i && deny;
    if (fetch_valid_o !== e_valid)
      report_mismatch("fetch_valid_o", 64'(fetch_valid_o), 64'(e_valid));
    if (e_valid && fetch_paddr_o !== e_pa)
      report_mismatch("fetch_paddr_o", 64'(fetch_paddr_o), 64'(e_pa));
    if (fetch_ex_valid_o !== e_exv)
      report_mismatch("fetch_ex_valid_o", 64'(fetch_ex_valid_o), 64'(e_exv));
    if (e_exv && fetch_ex_cause_o !== mmu_exc_pkg::CAUSE_INSTR_PAGE_FAULT)
      report_mismatch("fetch_ex_cause_o", 64'(fetch_ex_cause_o), 64'(12));
    if (e_exv && fetch_ex_tval_o !== fetch_vaddr_i)
      report_mismatch("fetch_ex_tval_o", 64'(fetch_ex_tval_o), 64'(fetch_vaddr_i));
    e_miss = fetch_req_i && enable_translation_i && !hit;
    if (itlb_miss_o !== e_miss)
      report_mismatch("itlb_miss_o", 64'(itlb_miss_o), 64'(e_miss));
  endtask

  // flush goes before any refill as in the DUT
  task automatic update_tlbs();
    if (flush_tlb_i) flush_entries(flush_asid_i, flush_vaddr_i);
    if (itlb_upd_valid_i) refill_entry(0, upd_vaddr_i, upd_asid_i, upd_is_4m_i, upd_pte_i);
    if (dtlb_upd_valid_i) refill_entry(1, upd_vaddr_i, upd_asid_i, upd_is_4m_i, upd_pte_i);
  endtask

  task automatic run_cycles(input int mode, input int count);
    repeat (count) begin
      @(posedge clk_i);
      #1;
      drive_inputs(mode);
      #4;
      check_outputs();
      update_tlbs();
      cycles++;
    end
  endtask

  // one pass-through load whose result must show up within a few cycles
  task automatic wait_first_result(output bit ok);
    @(posedge clk_i);
    #1;
    lsu_req_i   = 1'b1;
    lsu_vaddr_i = 32'h1234_5678;
    ok = 1'b0;
    for (int n = 0; n < 4 && !ok; n++) begin
      @(posedge clk_i);
      #1;
      lsu_req_i = 1'b0;
      if (lsu_valid_o) ok = 1'b1;
    end
  endtask

  initial begin : main
    bit ok;
    errors = 0;
    cycles = 0;
    void'($urandom(SEED));
    init_inputs();
    clear_tlbs();
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    wait_first_result(ok);
    if (!ok) begin
      errors++;
      $display("timeout, no lsu_valid_o within 4 cycles of the first request");
    end else begin
      run_cycles(0, 200);
      run_cycles(1, 3000);
      run_cycles(2, 500);
      run_cycles(1, 1000);
    end
    $display("checked %0d cycles, %0d errors", cycles, errors);
    if (errors == 0) $display("PASS: all tests");
    else $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

//--- sv32_mmu.f
+incdir+sim
source/sv32_pkg.sv
source/mmu_exc_pkg.sv
source/sv32_tlb.sv
source/instr_xlate.sv
source/data_xlate.sv
source/sv32_mmu.sv
sim/tb_sv32_mmu.sv

//--- run_sim.sh
#!/bin/sh
# build and run the sv32_mmu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_sv32_mmu -f sv32_mmu.f -o tb_sv32_mmu

./obj_dir/tb_sv32_mmu > sim.log 2>&1
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
  exit 1
fi
exit 0
